/* Makefile */
SIM  := obj_dir/Vtb_mdu_subsystem
SRCS := $(wildcard *.sv *.svh) files.f

.PHONY: all run clean

all: run

$(SIM): $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_mdu_subsystem

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -qx "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* e_mdu.sv */
`timescale 1ns/1ps
`default_nettype none

module e_mdu
    import mdu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     flush_i,
    input  mdu_req_t req_i,
    output logic     issue_ready_o,
    input  logic     fifo_ready_i,
    output logic     res_valid_o,
    output mdu_res_t res_o
);

    logic    s1_valid_q;
    mdu_op_u s1_op;
    rob_id_t s1_dest;
    word_t   s1_a;
    word_t   s1_b;
    logic    s2_valid_q;
    word_t   s2_data_q;
    rob_id_t s2_dest_q;
    logic    s1_adv;
    logic    s2_adv;

    logic signed [32:0] mul_a;
    logic signed [32:0] mul_b;
    logic signed [65:0] product;
    word_t              quot;
    word_t              rem;
    word_t              result;

    // a stage moves when it is empty or its successor moves
    assign s2_adv        = !s2_valid_q || fifo_ready_i;
    assign s1_adv        = !s1_valid_q || s2_adv;
    assign issue_ready_o = s1_adv;

    // ---------------------------------------------------------------------------
    // stage one, operand register
    // ---------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid_q <= 1'b0;
        end else if (flush_i) begin
            s1_valid_q <= 1'b0;
        end else if (s1_adv) begin
            s1_valid_q <= req_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_adv) begin
            s1_op   <= req_i.op;
            s1_dest <= req_i.dest;
            s1_a    <= req_i.a;
            s1_b    <= req_i.b;
        end
    end

    // ---------------------------------------------------------------------------
    // stage two, compute and result register
    // ---------------------------------------------------------------------------

    always_comb begin
        // extend by one bit, sign or zero
        mul_a   = {~s1_op.mul.uns & s1_a[31], s1_a};
        mul_b   = {~s1_op.mul.uns & s1_b[31], s1_b};
        product = mul_a * mul_b;

        if (s1_b == '0) begin
            quot = '1;
            rem  = s1_a;
        end else if (!s1_op.div.uns && s1_a == 32'h8000_0000 && s1_b == '1) begin
            // signed overflow case
            quot = s1_a;
            rem  = '0;
        end else if (s1_op.div.uns) begin
            quot = s1_a / s1_b;
            rem  = s1_a % s1_b;
        end else begin
            quot = $signed(s1_a) / $signed(s1_b);
            rem  = $signed(s1_a) % $signed(s1_b);
        end

        if (s1_op.div.is_div) begin
            result = s1_op.div.rem ? rem : quot;
        end else begin
            result = s1_op.mul.high ? product[63:32] : product[31:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s2_valid_q <= 1'b0;
        end else if (flush_i) begin
            s2_valid_q <= 1'b0;
        end else if (s2_adv) begin
            s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (s2_adv) begin
            s2_data_q <= result;
            s2_dest_q <= s1_dest;
        end
    end

    assign res_valid_o = s2_valid_q;
    assign res_o.dest  = s2_dest_q;
    assign res_o.data  = s2_data_q;

endmodule

`default_nettype wire

/* files.f */
+incdir+.
mdu_pkg.sv
iq_entry.sv
mdu_iq.sv
e_mdu.sv
mdu_result_fifo.sv
mdu_subsystem_top.sv
mdu_iq_props.sv
tb_mdu_subsystem.sv

/* iq_entry.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mdu_macros.svh"

module iq_entry
    import mdu_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      flush_i,
    input  logic                      init_i,
    input  logic                      select_i,
    input  dispatch_t                 entry_i,
    input  cdb_t [`MDU_CDB_COUNT-1:0] cdb_i,
    output logic                      occupied_o,
    output logic                      ready_o,
    output dispatch_t                 entry_o
);

    logic      occupied_q;
    dispatch_t entry_q;
    dispatch_t entry_d;

    // fill a waiting source from any matching broadcast
    function automatic src_t capture(src_t s, cdb_t [`MDU_CDB_COUNT-1:0] cdb);
        src_t r;
        r = s;
        for (int k = 0; k < `MDU_CDB_COUNT; k++) begin
            if (!s.valid && cdb[k].valid && cdb[k].tag == s.tag) begin
                r.valid = 1'b1;
                r.value = cdb[k].data;
            end
        end
        return r;
    endfunction

    // ---------------------------------------------------------------------------
    // micro-op storage
    // ---------------------------------------------------------------------------

    // new micro-op is checked against the CDB in its write cycle too
    always_comb begin
        entry_d = entry_q;
        if (init_i) begin
            entry_d = entry_i;
        end
        for (int s = 0; s < 2; s++) begin
            entry_d.src[s] = capture(entry_d.src[s], cdb_i);
        end
    end

    always_ff @(posedge clk) begin
        entry_q <= entry_d;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            occupied_q <= 1'b0;
        end else if (flush_i) begin
            occupied_q <= 1'b0;
        end else if (init_i) begin
            occupied_q <= 1'b1;
        end else if (select_i) begin
            occupied_q <= 1'b0;
        end
    end

    assign occupied_o = occupied_q;
    assign ready_o    = occupied_q && entry_q.src[0].valid && entry_q.src[1].valid;
    assign entry_o    = entry_q;

endmodule

`default_nettype wire

/* mdu_iq.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mdu_macros.svh"

module mdu_iq
    import mdu_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      flush_i,
    input  logic [1:0]                disp_valid_i,
    input  dispatch_t [1:0]           disp_i,
    output logic                      accept_o,
    input  cdb_t [`MDU_CDB_COUNT-1:0] cdb_i,
    output cdb_t                      wkup_o,
    input  logic                      issue_ready_i,
    output mdu_req_t                  req_o
);

    localparam int PTR_W = $clog2(`MDU_IQ_SIZE);
    localparam int CNT_W = PTR_W + 1;

    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;
    logic [PTR_W-1:0] head_d;
    logic [PTR_W-1:0] tail_d;
    logic [CNT_W-1:0] count_d;
    logic [PTR_W-1:0] lane1_slot;
    logic [1:0]       disp_v;
    logic [1:0]       n_disp;
    logic             issue;

    logic [`MDU_IQ_SIZE-1:0] entry_init;
    logic [`MDU_IQ_SIZE-1:0] entry_select;
    logic [`MDU_IQ_SIZE-1:0] entry_occupied;
    logic [`MDU_IQ_SIZE-1:0] entry_ready;
    dispatch_t               entry_wdata [`MDU_IQ_SIZE];
    dispatch_t               entry_data  [`MDU_IQ_SIZE];
    dispatch_t               head_entry;

    // ---------------------------------------------------------------------------
    // pointers and free-space level
    // ---------------------------------------------------------------------------

    // lanes only count when space was granted at the last edge
    assign disp_v = disp_valid_i & {2{accept_o}};
    assign n_disp = {1'b0, disp_v[0]} + {1'b0, disp_v[1]};

    assign head_d  = head_q + PTR_W'(issue);
    assign tail_d  = tail_q + PTR_W'(n_disp);
    assign count_d = count_q + CNT_W'(n_disp) - CNT_W'(issue);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q   <= '0;
            tail_q   <= '0;
            count_q  <= '0;
            accept_o <= 1'b1;
        end else if (flush_i) begin
            head_q   <= '0;
            tail_q   <= '0;
            count_q  <= '0;
            accept_o <= 1'b1;
        end else begin
            head_q   <= head_d;
            tail_q   <= tail_d;
            count_q  <= count_d;
            // room for two more, so both lanes can always land
            accept_o <= (count_d <= CNT_W'(`MDU_IQ_SIZE - 2));
        end
    end

    // ---------------------------------------------------------------------------
    // lane steering and entries
    // ---------------------------------------------------------------------------

    // lane 1 alone takes the tail, behind lane 0 it takes the next slot
    assign lane1_slot = disp_v[0] ? tail_q + PTR_W'(1) : tail_q;

    for (genvar i = 0; i < `MDU_IQ_SIZE; i++) begin : g_entry
        logic lane0_hit;
        logic lane1_hit;

        assign lane0_hit      = disp_v[0] && (tail_q == PTR_W'(i));
        assign lane1_hit      = disp_v[1] && (lane1_slot == PTR_W'(i));
        assign entry_init[i]  = lane0_hit || lane1_hit;
        assign entry_wdata[i] = lane1_hit ? disp_i[1] : disp_i[0];

        iq_entry iq_entry_inst (
            .clk        (clk),
            .rst_n_i    (rst_n_i),
            .flush_i    (flush_i),
            .init_i     (entry_init[i]),
            .select_i   (entry_select[i]),
            .entry_i    (entry_wdata[i]),
            .cdb_i      (cdb_i),
            .occupied_o (entry_occupied[i]),
            .ready_o    (entry_ready[i]),
            .entry_o    (entry_data[i])
        );
    end

    // ---------------------------------------------------------------------------
    // in-order issue from the head
    // ---------------------------------------------------------------------------

    assign head_entry   = entry_data[head_q];
    assign issue        = entry_occupied[head_q] && entry_ready[head_q] && issue_ready_i;
    assign entry_select = issue ? (`MDU_IQ_SIZE'(1) << head_q) : '0;

    always_comb begin
        req_o.valid  = issue;
        req_o.op     = head_entry.op;
        req_o.dest   = head_entry.dest;
        req_o.a      = head_entry.src[0].value;
        req_o.b      = head_entry.src[1].value;
        // early wakeup of the destination, data follows later
        wkup_o.valid = issue;
        wkup_o.tag   = head_entry.dest;
        wkup_o.data  = '0;
    end

endmodule

`default_nettype wire

/* mdu_iq_props.sv */
`timescale 1ns/1ps
`default_nettype none

module mdu_iq_props
    import mdu_pkg::*;
(
    input logic     clk,
    input logic     rst_n_i,
    input logic     flush_i,
    input logic     accept_i,
    input cdb_t     wkup_i,
    input logic     unit_valid_i,
    input logic     fifo_ready_i,
    input mdu_res_t unit_res_i
);

    // stage two keeps its result while the buffer is full
    property hold_when_full;
        @(posedge clk) disable iff (!rst_n_i || flush_i)
        unit_valid_i && !fifo_ready_i |=> unit_valid_i && $stable(unit_res_i);
    endproperty

    // queue is empty after flush, nothing can issue
    property quiet_after_flush;
        @(posedge clk) disable iff (!rst_n_i)
        flush_i |=> !wkup_i.valid;
    endproperty

    property accept_after_reset;
        @(posedge clk) $rose(rst_n_i) |-> accept_i;
    endproperty

    assert property (hold_when_full)
        else $error("result pushed while the result buffer was full");
    assert property (quiet_after_flush)
        else $error("wakeup pulse in the cycle after flush");
    assert property (accept_after_reset)
        else $error("accept low in the first cycle after reset");

endmodule

bind mdu_subsystem_top mdu_iq_props mdu_iq_props_inst (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .accept_i     (accept_o),
    .wkup_i       (wkup_o),
    .unit_valid_i (unit_valid),
    .fifo_ready_i (fifo_ready),
    .unit_res_i   (unit_res)
);

`default_nettype wire

/* mdu_macros.svh */
`ifndef MDU_MACROS_SVH
`define MDU_MACROS_SVH

// ---------------------------------------------------------------------------
// sizing of the multiply/divide issue path
// ---------------------------------------------------------------------------

// entries in the in-order issue queue
`define MDU_IQ_SIZE 4

// common data bus broadcast ports
`define MDU_CDB_COUNT 2

// entries in the result buffer
`define MDU_RES_DEPTH 4

`endif

/* mdu_pkg.sv */
`default_nettype none

package mdu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  rob_id_t;

    // multiply view of the op code
    typedef struct packed {
        logic is_div;
        logic high;
        logic uns;
    } mul_op_t;

    // divide view of the same bits
    typedef struct packed {
        logic is_div;
        logic rem;
        logic uns;
    } div_op_t;

    // is_div sits on the same bit in both views
    typedef union packed {
        mul_op_t mul;
        div_op_t div;
    } mdu_op_u;

    typedef struct packed {
        logic    valid;
        rob_id_t tag;
        word_t   value;
    } src_t;

    typedef struct packed {
        mdu_op_u    op;
        rob_id_t    dest;
        src_t [1:0] src;
    } dispatch_t;

    typedef struct packed {
        logic    valid;
        rob_id_t tag;
        word_t   data;
    } cdb_t;

    typedef struct packed {
        logic    valid;
        mdu_op_u op;
        rob_id_t dest;
        word_t   a;
        word_t   b;
    } mdu_req_t;

    typedef struct packed {
        rob_id_t dest;
        word_t   data;
    } mdu_res_t;

endpackage

`default_nettype wire

/* mdu_result_fifo.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mdu_macros.svh"

module mdu_result_fifo
    import mdu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     flush_i,
    input  logic     push_i,
    input  mdu_res_t push_data_i,
    output logic     ready_o,
    input  logic     pop_i,
    output logic     valid_o,
    output mdu_res_t data_o
);

    localparam int PTR_W = $clog2(`MDU_RES_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    mdu_res_t         mem [`MDU_RES_DEPTH];
    logic [PTR_W-1:0] wptr_q;
    logic [PTR_W-1:0] rptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    assign ready_o = (count_q != CNT_W'(`MDU_RES_DEPTH));
    assign valid_o = (count_q != '0);
    assign do_push = push_i && ready_o;
    // pop on an empty buffer does nothing
    assign do_pop  = pop_i && valid_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else begin
            wptr_q  <= wptr_q + PTR_W'(do_push);
            rptr_q  <= rptr_q + PTR_W'(do_pop);
            count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wptr_q] <= push_data_i;
        end
    end

    assign data_o = mem[rptr_q];

endmodule

`default_nettype wire

/* mdu_subsystem_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mdu_macros.svh"

module mdu_subsystem_top
    import mdu_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      flush_i,
    input  logic [1:0]                disp_valid_i,
    input  dispatch_t [1:0]           disp_i,
    output logic                      accept_o,
    input  cdb_t [`MDU_CDB_COUNT-1:0] cdb_i,
    output cdb_t                      wkup_o,
    input  logic                      res_pop_i,
    output logic                      res_valid_o,
    output mdu_res_t                  res_o
);

    mdu_req_t req;
    logic     issue_ready;
    logic     fifo_ready;
    logic     unit_valid;
    mdu_res_t unit_res;

    mdu_iq mdu_iq_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .disp_valid_i  (disp_valid_i),
        .disp_i        (disp_i),
        .accept_o      (accept_o),
        .cdb_i         (cdb_i),
        .wkup_o        (wkup_o),
        .issue_ready_i (issue_ready),
        .req_o         (req)
    );

    e_mdu e_mdu_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .req_i         (req),
        .issue_ready_o (issue_ready),
        .fifo_ready_i  (fifo_ready),
        .res_valid_o   (unit_valid),
        .res_o         (unit_res)
    );

    // stage two holds its result until the buffer has room
    mdu_result_fifo mdu_result_fifo_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .push_i      (unit_valid),
        .push_data_i (unit_res),
        .ready_o     (fifo_ready),
        .pop_i       (res_pop_i),
        .valid_o     (res_valid_o),
        .data_o      (res_o)
    );

endmodule

`default_nettype wire

/* tb_mdu_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mdu_macros.svh"

module tb_mdu_subsystem
    import mdu_pkg::*;
();

    logic                      clk;
    logic                      rst_n_i;
    logic                      flush_i;
    logic [1:0]                disp_valid_i;
    dispatch_t [1:0]           disp_i;
    logic                      accept_o;
    cdb_t [`MDU_CDB_COUNT-1:0] cdb_i;
    cdb_t                      wkup_o;
    logic                      res_pop_i;
    logic                      res_valid_o;
    mdu_res_t                  res_o;

    // MUL, MULH, MULHU, then the four divide codes
    logic [2:0] op_codes [7] = '{3'b000, 3'b010, 3'b011, 3'b100, 3'b101, 3'b110, 3'b111};
    word_t      corner_a [6];
    word_t      corner_b [6];

    mdu_res_t exp_q [$];
    rob_id_t  wkup_q [$];
    cdb_t     pend_cdb [$];
    int       pend_due [$];

    mdu_res_t    exp_res;
    rob_id_t     exp_tag;
    rob_id_t     dest_ctr;
    rob_id_t     src_ctr;
    int          wait_pct;
    int          dual_pct;
    int          pop_pct;
    int          cycles = 0;
    int          n_sent = 0;
    int          n_res = 0;
    int          n_wkup = 0;
    int          errors = 0;
    int          end_errors;
    logic        saw_accept_low = 1'b0;
    int unsigned seed;

    mdu_subsystem_top mdu_subsystem_top_inst (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .disp_valid_i (disp_valid_i),
        .disp_i       (disp_i),
        .accept_o     (accept_o),
        .cdb_i        (cdb_i),
        .wkup_o       (wkup_o),
        .res_pop_i    (res_pop_i),
        .res_valid_o  (res_valid_o),
        .res_o        (res_o)
    );

    always #4 clk = ~clk;

    // ---------------------------------------------------------------------------
    // reference model
    // ---------------------------------------------------------------------------

    function automatic word_t mdu_ref(input mdu_op_u op, input word_t a, input word_t b);
        logic [63:0] p;
        if (!op.mul.is_div) begin
            if (op.mul.uns) begin
                p = {32'b0, a} * {32'b0, b};
            end else begin
                p = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
            end
            return op.mul.high ? p[63:32] : p[31:0];
        end
        if (b == 32'h0) begin
            return op.div.rem ? a : 32'hffff_ffff;
        end
        if (!op.div.uns && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            return op.div.rem ? 32'h0 : a;
        end
        if (op.div.uns) begin
            return op.div.rem ? a % b : a / b;
        end
        if (op.div.rem) begin
            return word_t'($signed(a) % $signed(b));
        end
        return word_t'($signed(a) / $signed(b));
    endfunction

    function automatic word_t random_word();
        word_t corners [5];
        corners = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
        if (($urandom % 100) < 30) begin
            return corners[$urandom % 5];
        end
        return $urandom;
    endfunction

    function automatic mdu_op_u random_op();
        return mdu_op_u'(op_codes[$urandom % 7]);
    endfunction

    // ---------------------------------------------------------------------------
    // stimulus
    // ---------------------------------------------------------------------------

    // delay 0 goes out now when a port is free
    function automatic void broadcast(rob_id_t tag, word_t data, int delay);
        cdb_t c;
        logic placed;
        int   k;
        c.valid = 1'b1;
        c.tag   = tag;
        c.data  = data;
        placed  = 1'b0;
        if (delay == 0) begin
            for (int j = 0; j < `MDU_CDB_COUNT; j++) begin
                k = (j + int'($urandom % `MDU_CDB_COUNT)) % `MDU_CDB_COUNT;
                if (!placed && !cdb_i[k].valid) begin
                    cdb_i[k] = c;
                    placed   = 1'b1;
                end
            end
        end
        if (!placed) begin
            pend_cdb.push_back(c);
            pend_due.push_back(cycles + delay);
        end
    endfunction

    // one cycle, inputs change 1 ns after the edge
    task automatic tick();
        int used;
        int base;
        int i;
        @(posedge clk);
        #1;
        flush_i      = 1'b0;
        disp_valid_i = '0;
        disp_i       = '0;
        cdb_i        = '0;
        res_pop_i    = ($urandom % 100) < pop_pct;
        used = 0;
        base = int'($urandom % `MDU_CDB_COUNT);
        i    = 0;
        while (i < pend_due.size() && used < `MDU_CDB_COUNT) begin
            if (pend_due[i] <= cycles) begin
                cdb_i[(base + used) % `MDU_CDB_COUNT] = pend_cdb[i];
                pend_cdb.delete(i);
                pend_due.delete(i);
                used++;
            end else begin
                i++;
            end
        end
    endtask

    task automatic load_lane(int lane, mdu_op_u op, word_t a, word_t b);
        dispatch_t d;
        mdu_res_t  e;
        word_t     v [2];
        v[0]   = a;
        v[1]   = b;
        d.op   = op;
        d.dest = dest_ctr;
        for (int s = 0; s < 2; s++) begin
            if (($urandom % 100) < wait_pct) begin
                // junk value, the broadcast must replace it
                d.src[s].valid = 1'b0;
                d.src[s].tag   = src_ctr;
                d.src[s].value = $urandom;
                broadcast(src_ctr, v[s], int'($urandom % 4));
                src_ctr++;
            end else begin
                d.src[s].valid = 1'b1;
                d.src[s].tag   = rob_id_t'($urandom);
                d.src[s].value = v[s];
            end
        end
        disp_i[lane]       = d;
        disp_valid_i[lane] = 1'b1;
        e.dest = d.dest;
        e.data = mdu_ref(op, a, b);
        exp_q.push_back(e);
        wkup_q.push_back(d.dest);
        dest_ctr++;
        n_sent++;
    endtask

    task automatic traffic(int n_cycles);
        repeat (n_cycles) begin
            tick();
            if (accept_o && ($urandom % 100) < 70) begin
                if (($urandom % 100) < dual_pct) begin
                    load_lane(0, random_op(), random_word(), random_word());
                    load_lane(1, random_op(), random_word(), random_word());
                end else begin
                    load_lane(int'($urandom % 2), random_op(), random_word(), random_word());
                end
            end
        end
    endtask

    task automatic flush_all();
        tick();
        flush_i   = 1'b1;
        res_pop_i = 1'b0;
        cdb_i     = '0;
        exp_q.delete();
        wkup_q.delete();
        pend_cdb.delete();
        pend_due.delete();
    endtask

    // ---------------------------------------------------------------------------
    // checking
    // ---------------------------------------------------------------------------

    always @(posedge clk) begin
        cycles++;
        if (cycles > 40 * n_sent + 200) begin
            $display("timeout after %0d cycles, %0d results never arrived", cycles, exp_q.size());
            $display("Testbench failed");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (rst_n_i && !flush_i) begin
            // only a fall while pops are withheld counts as back-pressure
            if (!accept_o && pop_pct == 0) begin
                saw_accept_low = 1'b1;
            end
            if (wkup_o.valid) begin
                assert (wkup_q.size() > 0) else begin
                    errors++;
                    $display("wakeup for tag %0d with no micro-op outstanding", wkup_o.tag);
                end
                assert (wkup_o.data == 32'h0) else begin
                    errors++;
                    $display("[FAIL] %0t wkup_o.data got %08h expected %08h",
                             $time, wkup_o.data, 32'h0);
                end
                if (wkup_q.size() > 0) begin
                    exp_tag = wkup_q.pop_front();
                    n_wkup++;
                    assert (wkup_o.tag == exp_tag) else begin
                        errors++;
                        $display("[FAIL] %0t wkup_o.tag got %0d expected %0d",
                                 $time, wkup_o.tag, exp_tag);
                    end
                end
            end
            if (res_valid_o && res_pop_i) begin
                assert (exp_q.size() > 0) else begin
                    errors++;
                    $display("result for dest %0d came out with nothing expected", res_o.dest);
                end
                if (exp_q.size() > 0) begin
                    exp_res = exp_q.pop_front();
                    n_res++;
                    assert (res_o.dest == exp_res.dest) else begin
                        errors++;
                        $display("[FAIL] %0t res_o.dest got %0d expected %0d",
                                 $time, res_o.dest, exp_res.dest);
                    end
                    assert (res_o.data == exp_res.data) else begin
                        errors++;
                        $display("[FAIL] %0t res_o.data got %08h expected %08h",
                                 $time, res_o.data, exp_res.data);
                    end
                end
            end
        end
    end

    initial begin
        seed         = $urandom(32'h427d);
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        flush_i      = 1'b0;
        disp_valid_i = '0;
        disp_i       = '0;
        cdb_i        = '0;
        res_pop_i    = 1'b0;
        dest_ctr     = '0;
        src_ctr      = '0;
        wait_pct     = 0;
        dual_pct     = 0;
        pop_pct      = 100;
        end_errors   = 0;
        corner_a     = '{32'h0, 32'h8000_0000, 32'h1234_5678, 32'hffff_ffff, 32'h0, 32'h8000_0000};
        corner_b     = '{32'h0, 32'hffff_ffff, 32'h0, 32'h8000_0000, 32'h0, 32'h7};
        corner_a[0]  = $urandom;
        corner_b[0]  = $urandom;
        repeat (10) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        // every op code on corner operands, one lane at a time
        for (int c = 0; c < 7; c++) begin
            for (int p = 0; p < 6; p++) begin
                do begin
                    tick();
                end while (!accept_o);
                load_lane(p % 2, mdu_op_u'(op_codes[c]), corner_a[p], corner_b[p]);
            end
        end

        // both lanes, sources woken from the cdb
        wait_pct = 50;
        dual_pct = 80;
        traffic(300);

        // long stretches without pops fill the buffer and the queue
        for (int r = 0; r < 6; r++) begin
            pop_pct = 0;
            traffic(20 + int'($urandom % 40));
            pop_pct = 80;
            traffic(10 + int'($urandom % 20));
        end

        // flush with results in flight, then fresh traffic
        pop_pct = 40;
        traffic(30);
        flush_all();
        pop_pct = 90;
        traffic(150);

        pop_pct = 100;
        while (exp_q.size() > 0 || wkup_q.size() > 0) begin
            tick();
        end
        repeat (20) tick();

        assert (saw_accept_low) else begin
            end_errors++;
            $display("accept_o never fell while results were held back");
        end
        $display("results checked %0d, wakeups checked %0d, errors %0d",
                 n_res, n_wkup, errors + end_errors);
        if (errors + end_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
